// File: Makefile
TOP := tbBtVideo

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --top-module $(TOP) -f btVideo.f -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

lint:
	verilator --lint-only --timing --top-module $(TOP) -f btVideo.f

clean:
	rm -rf obj_dir sim.log

// File: btVideo.f
+incdir+rtl
rtl/btPkg.sv
rtl/btHostRegs.sv
rtl/btSoundLatch.sv
rtl/btPaletteLoader.sv
rtl/btPaletteRam.sv
rtl/btPixelMixer.sv
rtl/btVideo.sv
testbench/tbBtVideo.sv

// File: rtl/btHostRegs.sv
`include "btVideo_defs.svh"

`default_nettype none

module btHostRegs import btPkg::*; (
	input  logic       CLK,
	input  logic       RST_N,
	input  logic       ce,
	input  hostBus_t   host,
	input  logic [7:0] p1,
	input  logic [7:0] p2,
	input  logic [7:0] p3,
	input  logic [7:0] sw1,
	input  logic       service,
	input  logic       ctrlRdy,
	input  logic       respRdy,
	input  logic [7:0] respData,
	output logic [7:0] hostRdata,
	output mixMode_e   mixMode,
	output logic       sndRstN,
	output logic       palAddrWr,
	output logic       palDataWr,
	output logic       cmdWr,
	output logic       respRd,
	output logic [7:0] wrByte
);

	logic hostWr;
	logic hostRd;
	logic dispWr;
	logic miscWr;

	assign hostWr = ce && host.sel && host.wr;
	assign hostRd = ce && host.sel && host.rd;

	assign dispWr    = hostWr && host.regIdx == REG_DISP_CTRL;
	assign palAddrWr = hostWr && host.regIdx == REG_PAL_ADDR;
	assign palDataWr = hostWr && host.regIdx == REG_PAL_DATA;
	assign cmdWr     = hostWr && host.regIdx == REG_SND_CMD;
	assign miscWr    = hostWr && host.regIdx == REG_MISC_CTRL;
	assign respRd    = hostRd && host.regIdx == REG_SND_CMD; // frees the response slot

	assign wrByte = host.wdata[7:0];

	// only the priority field and the sound reset bit are kept
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			mixMode <= MIX_SPR_FRONT;
			sndRstN <= 1'b0;
		end else begin
			if (dispWr)
				mixMode <= mixMode_e'(host.wdata[9:8]);
			if (miscWr)
				sndRstN <= host.wdata[`BT_MISC_SND_RST];
		end
	end

	always_comb begin
		hostRdata = 8'hFF;
		if (host.sel) begin
			case (host.regIdx)
				REG_P1:      hostRdata = p1;
				REG_P2:      hostRdata = p2;
				REG_P3:      hostRdata = p3;
				REG_SW1:     hostRdata = sw1;
				REG_STATUS:  hostRdata = {ctrlRdy, 5'b00000, service, respRdy};
				REG_SND_CMD: hostRdata = respData;
				default:     hostRdata = 8'hFF;
			endcase
		end
	end

	// a host cycle reaches exactly one neighbour
	assert property (@(posedge CLK) disable iff (!RST_N)
		$onehot0({dispWr, palAddrWr, palDataWr, cmdWr, miscWr}))
		else $error("btHostRegs: overlapping write strobes");

endmodule

`default_nettype wire

// File: rtl/btPaletteLoader.sv
`include "btVideo_defs.svh"

`default_nettype none

module btPaletteLoader import btPkg::*; (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  logic                 ce,
	input  logic                 palAddrWr,
	input  logic                 palDataWr,
	input  logic [7:0]           wrByte,
	output logic                 palWe,
	output logic [`BT_PIX_W-1:0] palWaddr,
	output palEntry_t            palWdata
);

	logic [`BT_PIX_W-1:0]    wAddr;
	logic [1:0]              byteCnt; // 0 red, 1 green, 2 blue
	logic [`BT_PAL_CH_W-1:0] red;
	logic [`BT_PAL_CH_W-1:0] green;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			wAddr   <= '0;
			byteCnt <= 2'd0;
			palWe   <= 1'b0;
		end else if (ce) begin
			palWe <= 1'b0;
			if (palAddrWr) begin
				wAddr   <= wrByte;
				byteCnt <= 2'd0;
			end else if (palDataWr) begin
				if (byteCnt == 2'd2) begin
					byteCnt <= 2'd0;
					wAddr   <= wAddr + `BT_PIX_W'(1); // auto-increment for the next triple
					palWe   <= 1'b1;
				end else begin
					byteCnt <= byteCnt + 2'd1;
				end
			end
		end
	end

	// DAC takes the low 6 bits of each byte
	always_ff @(posedge CLK) begin
		if (ce && palDataWr) begin
			case (byteCnt)
				2'd0: red <= wrByte[`BT_PAL_CH_W-1:0];
				2'd1: green <= wrByte[`BT_PAL_CH_W-1:0];
				default: begin
					palWaddr <= wAddr;
					palWdata <= {red, green, wrByte[`BT_PAL_CH_W-1:0]};
				end
			endcase
		end
	end

	assert property (@(posedge CLK) disable iff (!RST_N) byteCnt != 2'd3)
		else $error("btPaletteLoader: byte count out of range");

endmodule

`default_nettype wire

// File: rtl/btPaletteRam.sv
`include "btVideo_defs.svh"

`default_nettype none

module btPaletteRam import btPkg::*; (
	input  logic                 CLK,
	input  logic                 ce,
	input  logic                 palWe,
	input  logic [`BT_PIX_W-1:0] palWaddr,
	input  palEntry_t            palWdata,
	input  logic [`BT_PIX_W-1:0] pixel,
	output rgb_t                 rgb
);

	localparam int CH = `BT_PAL_CH_W;

	palEntry_t palMem [`BT_PAL_DEPTH];
	palEntry_t lookup;

	always_ff @(posedge CLK) begin
		if (palWe && ce)
			palMem[palWaddr] <= palWdata;
	end

	// display port, free running
	always_ff @(posedge CLK) begin
		lookup <= palMem[pixel];
	end

	// repeat the top two bits so full scale stays full scale
	assign rgb.r = {lookup.r, lookup.r[CH-1 -: 2]};
	assign rgb.g = {lookup.g, lookup.g[CH-1 -: 2]};
	assign rgb.b = {lookup.b, lookup.b[CH-1 -: 2]};

endmodule

`default_nettype wire

// File: rtl/btPixelMixer.sv
`include "btVideo_defs.svh"

`default_nettype none

module btPixelMixer import btPkg::*; (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  layerPix_t            layers,
	input  logic [2:0]           layerEn, // bg0, bg1, spr from bit 0
	input  mixMode_e             mixMode,
	output logic [`BT_PIX_W-1:0] pixel
);

	logic [`BT_PIX_W-1:0] nextPix;
	logic                 bg0Vis;
	logic                 bg1Vis;
	logic                 sprVis;
	logic                 bg1Hi;
	logic                 sprHi;
	logic                 sprLo;

	assign bg0Vis = |layers.bg0 && layerEn[0];
	assign bg1Vis = |layers.bg1 && layerEn[1];
	assign sprVis = |layers.spr && layerEn[2];
	assign bg1Hi  = layers.bg1[7] && layerEn[1]; // high bank jumps ahead
	assign sprHi  = layers.spr[7] && layerEn[2];
	assign sprLo  = sprVis && !layers.spr[7];

	always_comb begin
		nextPix = '0;
		case (mixMode)
			MIX_SPR_FRONT: begin
				if (sprLo) nextPix = layers.spr;
				else if (bg1Hi) nextPix = layers.bg1;
				else if (sprVis) nextPix = layers.spr;
				else if (bg1Vis) nextPix = layers.bg1;
				else if (layerEn[0]) nextPix = layers.bg0;
			end
			MIX_BG0_FRONT: begin
				if (sprLo) nextPix = layers.spr;
				else if (bg0Vis) nextPix = layers.bg0;
				else if (bg1Hi) nextPix = layers.bg1;
				else if (sprVis) nextPix = layers.spr;
				else if (layerEn[1]) nextPix = layers.bg1;
			end
			MIX_SPR_OVER: begin
				if (sprVis) nextPix = layers.spr;
				else if (bg1Vis) nextPix = layers.bg1;
				else if (layerEn[0]) nextPix = layers.bg0;
			end
			MIX_BG1_FRONT: begin
				if (bg1Hi) nextPix = layers.bg1;
				else if (sprHi) nextPix = layers.spr;
				else if (bg1Vis) nextPix = layers.bg1;
				else if (sprVis) nextPix = layers.spr;
				else if (layerEn[0]) nextPix = layers.bg0;
			end
			default: nextPix = '0;
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N)
			pixel <= '0;
		else
			pixel <= nextPix;
	end

	// nothing enabled means backdrop index 0
	assert property (@(posedge CLK) disable iff (!RST_N) layerEn == 3'b000 |=> pixel == '0)
		else $error("btPixelMixer: pixel leaked with all layers off");

endmodule

`default_nettype wire

// File: rtl/btPkg.sv
`include "btVideo_defs.svh"

`default_nettype none

package btPkg;

	typedef enum logic [`BT_REG_IDX_W-1:0] {
		REG_P1        = 7'h00,
		REG_P2        = 7'h04,
		REG_P3        = 7'h08,
		REG_DISP_CTRL = 7'h0C,
		REG_STATUS    = 7'h10,
		REG_SW1       = 7'h14,
		REG_PAL_ADDR  = 7'h18, // DAC write address
		REG_PAL_DATA  = 7'h19, // DAC colour bytes, r/g/b
		REG_SND_CMD   = 7'h1C, // command out, response in
		REG_MISC_CTRL = 7'h20
	} hostReg_e;

	// display control bits 9:8
	typedef enum logic [1:0] {
		MIX_SPR_FRONT = 2'd0,
		MIX_BG0_FRONT = 2'd1,
		MIX_SPR_OVER  = 2'd2,
		MIX_BG1_FRONT = 2'd3
	} mixMode_e;

	typedef enum logic [2:0] {
		SND_DATA      = 3'd0,
		SND_CMD_STAT  = 3'd4,
		SND_RESP_STAT = 3'd5
	} sndPort_e;

	typedef struct packed {
		logic                     sel;
		logic                     wr;
		logic                     rd;
		logic [`BT_REG_IDX_W-1:0] regIdx;
		logic [`BT_HOST_DW-1:0]   wdata;
	} hostBus_t;

	typedef struct packed {
		logic       wr;
		logic       rd;
		sndPort_e   port;
		logic [7:0] data;
	} sndBus_t;

	typedef struct packed {
		logic [`BT_PIX_W-1:0] bg0;
		logic [`BT_PIX_W-1:0] bg1;
		logic [`BT_PIX_W-1:0] spr;
	} layerPix_t;

	typedef struct packed {
		logic [`BT_PAL_CH_W-1:0] r;
		logic [`BT_PAL_CH_W-1:0] g;
		logic [`BT_PAL_CH_W-1:0] b;
	} palEntry_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

endpackage

`default_nettype wire

// File: rtl/btSoundLatch.sv
`default_nettype none

module btSoundLatch import btPkg::*; (
	input  logic       CLK,
	input  logic       RST_N,
	input  logic       cmdWr,
	input  logic       respRd,
	input  logic [7:0] wrByte,
	input  sndBus_t    snd,
	output logic [7:0] sndRdata,
	output logic       ctrlRdy,
	output logic       respRdy,
	output logic [7:0] respData
);

	logic [7:0] cmdData;
	logic       sndDataRd;
	logic       sndDataWr;

	assign sndDataRd = snd.rd && snd.port == SND_DATA;
	assign sndDataWr = snd.wr && snd.port == SND_DATA;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ctrlRdy <= 1'b0;
			respRdy <= 1'b0;
		end else begin
			if (cmdWr)
				ctrlRdy <= 1'b1;
			if (sndDataRd)
				ctrlRdy <= 1'b0; // sound side took the command
			if (respRd)
				respRdy <= 1'b0;
			if (sndDataWr)
				respRdy <= 1'b1; // new response wins over a host read
		end
	end

	always_ff @(posedge CLK) begin
		if (cmdWr)
			cmdData <= wrByte;
		if (sndDataWr)
			respData <= snd.data;
		if (snd.rd) begin
			case (snd.port)
				SND_DATA:      sndRdata <= cmdData;
				SND_CMD_STAT:  sndRdata <= {~ctrlRdy, 7'b0000000}; // low means pending
				SND_RESP_STAT: sndRdata <= {~respRdy, 7'b0000000};
				default:       sndRdata <= 8'h00;
			endcase
		end
	end

	assert property (@(posedge CLK) disable iff (!RST_N) !(snd.rd && snd.wr))
		else $error("btSoundLatch: sound rd and wr together");

endmodule

`default_nettype wire

// File: rtl/btVideo.sv
`include "btVideo_defs.svh"

`default_nettype none

module btVideo import btPkg::*; (
	input  logic       CLK,
	input  logic       RST_N,
	input  logic       ce,
	input  hostBus_t   host,
	input  sndBus_t    snd,
	input  layerPix_t  layers,
	input  logic [2:0] layerEn,
	input  logic [7:0] p1,
	input  logic [7:0] p2,
	input  logic [7:0] p3,
	input  logic [7:0] sw1,
	input  logic       service,
	output logic [7:0] hostRdata,
	output logic [7:0] sndRdata,
	output rgb_t       rgb,
	output logic       sndRstN
);

	mixMode_e             mixMode;
	logic                 palAddrWr;
	logic                 palDataWr;
	logic                 cmdWr;
	logic                 respRd;
	logic [7:0]           wrByte;
	logic                 ctrlRdy;
	logic                 respRdy;
	logic [7:0]           respData;
	logic                 palWe;
	logic [`BT_PIX_W-1:0] palWaddr;
	palEntry_t            palWdata;
	logic [`BT_PIX_W-1:0] pixel;

	btHostRegs hostRegs (
		.CLK(CLK), .RST_N(RST_N), .ce(ce),
		.host(host),
		.p1(p1), .p2(p2), .p3(p3), .sw1(sw1), .service(service),
		.ctrlRdy(ctrlRdy), .respRdy(respRdy), .respData(respData),
		.hostRdata(hostRdata), .mixMode(mixMode), .sndRstN(sndRstN),
		.palAddrWr(palAddrWr), .palDataWr(palDataWr),
		.cmdWr(cmdWr), .respRd(respRd), .wrByte(wrByte)
	);

	btSoundLatch soundLatch (
		.CLK(CLK), .RST_N(RST_N),
		.cmdWr(cmdWr), .respRd(respRd), .wrByte(wrByte),
		.snd(snd), .sndRdata(sndRdata),
		.ctrlRdy(ctrlRdy), .respRdy(respRdy), .respData(respData)
	);

	btPaletteLoader palLoader (
		.CLK(CLK), .RST_N(RST_N), .ce(ce),
		.palAddrWr(palAddrWr), .palDataWr(palDataWr), .wrByte(wrByte),
		.palWe(palWe), .palWaddr(palWaddr), .palWdata(palWdata)
	);

	btPixelMixer mixer (
		.CLK(CLK), .RST_N(RST_N),
		.layers(layers), .layerEn(layerEn), .mixMode(mixMode),
		.pixel(pixel)
	);

	// two cycles from layers to colour
	btPaletteRam palRam (
		.CLK(CLK), .ce(ce),
		.palWe(palWe), .palWaddr(palWaddr), .palWdata(palWdata),
		.pixel(pixel), .rgb(rgb)
	);

endmodule

`default_nettype wire

// File: rtl/btVideo_defs.svh
`ifndef BT_VIDEO_DEFS_SVH
`define BT_VIDEO_DEFS_SVH

`default_nettype none

// host window, already decoded down to a register index
`define BT_REG_IDX_W 7
`define BT_HOST_DW 16

// layer pixels double as palette indices
`define BT_PIX_W 8

// DAC channels are 6 bits, widened to 8 at the output
`define BT_PAL_CH_W 6
`define BT_PAL_DEPTH 256

// misc control bit that releases the sound CPU
`define BT_MISC_SND_RST 3

`default_nettype wire

`endif

// File: testbench/tbBtVideo.sv
`include "btVideo_defs.svh"

`default_nettype none

module tbBtVideo import btPkg::*;;

	localparam int TEST_CYCLES = 10 + 20 + 50 + 950 + 15 + 15 + 10;

	logic       CLK;
	logic       RST_N;
	logic       ce;
	hostBus_t   host;
	sndBus_t    snd;
	layerPix_t  layers;
	logic [2:0] layerEn;
	logic [7:0] p1;
	logic [7:0] p2;
	logic [7:0] p3;
	logic [7:0] sw1;
	logic       service;
	logic [7:0] hostRdata;
	logic [7:0] sndRdata;
	rgb_t       rgb;
	logic       sndRstN;

	logic [15:0] lfsr = 16'd45525;
	palEntry_t   palModel [256];
	rgb_t        expQ [$];
	int          errors = 0;
	int          testsRun = 0;
	int          testsFailed = 0;
	int          errStart = 0;

	btVideo uut (
		.CLK(CLK), .RST_N(RST_N), .ce(ce),
		.host(host), .snd(snd), .layers(layers), .layerEn(layerEn),
		.p1(p1), .p2(p2), .p3(p3), .sw1(sw1), .service(service),
		.hostRdata(hostRdata), .sndRdata(sndRdata), .rgb(rgb), .sndRstN(sndRstN)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// misc write must show up on sndRstN one edge later
	assert property (@(posedge CLK) disable iff (!RST_N)
		ce && host.sel && host.wr && host.regIdx == REG_MISC_CTRL
		|=> sndRstN == $past(host.wdata[`BT_MISC_SND_RST]))
		else begin
			errors++;
			$display("sndRstN did not follow the misc control write");
		end

	function automatic logic [7:0] randBits(input int n);
		logic [7:0] r;
		logic       fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]; // taps 16,14,13,11
			lfsr = {lfsr[14:0], fb};
			r = {r[6:0], fb};
		end
		return r;
	endfunction

	function automatic logic [7:0] randLayer();
		if (randBits(2) == 8'd0)
			return 8'h00; // transparent now and then
		return randBits(8);
	endfunction

	function automatic logic [7:0] statusByte(input logic ctrl, input logic resp);
		return {ctrl, 5'b00000, service, resp};
	endfunction

	function automatic rgb_t expand(input palEntry_t e);
		return '{r: {e.r, e.r[5:4]}, g: {e.g, e.g[5:4]}, b: {e.b, e.b[5:4]}};
	endfunction

	function automatic logic [7:0] mixRef(input layerPix_t l, input logic [2:0] en,
		input mixMode_e m);
		logic b0Vis;
		logic b1Vis;
		logic spVis;
		logic b1Top;
		logic spTop;
		b0Vis = en[0] && l.bg0 != 8'h00;
		b1Vis = en[1] && l.bg1 != 8'h00;
		spVis = en[2] && l.spr != 8'h00;
		b1Top = en[1] && l.bg1[7];
		spTop = en[2] && l.spr[7];
		case (m)
			MIX_SPR_FRONT: begin
				if (spVis && !l.spr[7]) return l.spr;
				if (b1Top) return l.bg1;
				if (spVis) return l.spr;
				if (b1Vis) return l.bg1;
				if (en[0]) return l.bg0;
			end
			MIX_BG0_FRONT: begin
				if (spVis && !l.spr[7]) return l.spr;
				if (b0Vis) return l.bg0;
				if (b1Top) return l.bg1;
				if (spVis) return l.spr;
				if (en[1]) return l.bg1;
			end
			MIX_SPR_OVER: begin
				if (spVis) return l.spr;
				if (b1Vis) return l.bg1;
				if (en[0]) return l.bg0;
			end
			default: begin
				if (b1Top) return l.bg1;
				if (spTop) return l.spr;
				if (b1Vis) return l.bg1;
				if (spVis) return l.spr;
				if (en[0]) return l.bg0;
			end
		endcase
		return 8'h00;
	endfunction

	task automatic checkByte(input string name, input logic [7:0] exp, input logic [7:0] got);
		assert (got === exp) else begin
			errors++;
			$display("FAIL %s expected %h actual %h", name, exp, got);
		end
	endtask

	task automatic checkRgb(input string name, input rgb_t exp, input rgb_t got);
		assert (got === exp) else begin
			errors++;
			$display("FAIL %s expected %h actual %h", name, exp, got);
		end
	endtask

	task automatic beginTest();
		errStart = errors;
	endtask

	task automatic endTest(input string name);
		testsRun++;
		if (errors != errStart) begin
			testsFailed++;
			$display("test %s: %0d errors", name, errors - errStart);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	task automatic hostWrite(input logic [6:0] idx, input logic [15:0] data);
		host = '{sel: 1'b1, wr: 1'b1, rd: 1'b0, regIdx: idx, wdata: data};
		@(posedge CLK);
		#2;
		host = '0;
	endtask

	task automatic hostRead(input logic [6:0] idx, output logic [7:0] data);
		host = '{sel: 1'b1, wr: 1'b0, rd: 1'b1, regIdx: idx, wdata: 16'h0000};
		@(negedge CLK);
		data = hostRdata;
		@(posedge CLK);
		#2;
		host = '0;
	endtask

	task automatic sndRead(input sndPort_e port, output logic [7:0] data);
		snd = '{wr: 1'b0, rd: 1'b1, port: port, data: 8'h00};
		@(posedge CLK);
		#2;
		snd = '0;
		@(negedge CLK); // registered one cycle after the strobe
		data = sndRdata;
		@(posedge CLK);
		#2;
	endtask

	task automatic sndWrite(input logic [7:0] data);
		snd = '{wr: 1'b1, rd: 1'b0, port: SND_DATA, data: data};
		@(posedge CLK);
		#2;
		snd = '0;
	endtask

	task automatic palTriple(input logic [7:0] r, input logic [7:0] g, input logic [7:0] b);
		hostWrite(REG_PAL_DATA, {8'h00, r});
		hostWrite(REG_PAL_DATA, {8'h00, g});
		hostWrite(REG_PAL_DATA, {8'h00, b});
	endtask

	// one pixel per cycle, rgb checked two cycles behind
	task automatic pixStep(input string name, input layerPix_t l, input logic [2:0] en,
		input rgb_t exp);
		layers = l;
		layerEn = en;
		expQ.push_back(exp);
		@(negedge CLK);
		if (expQ.size() > 2)
			checkRgb(name, expQ.pop_front(), rgb);
		@(posedge CLK);
		#2;
	endtask

	task automatic pixFlush(input string name);
		while (expQ.size() > 0) begin
			@(negedge CLK);
			checkRgb(name, expQ.pop_front(), rgb);
			@(posedge CLK);
			#2;
		end
	endtask

	initial begin
		#(TEST_CYCLES * 20 * 3 / 2);
		$display("timeout: the tests did not finish in time");
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		logic [7:0] rdVal;
		logic [7:0] start;
		logic [7:0] idx;
		logic [7:0] cr;
		logic [7:0] cg;
		logic [7:0] cb;
		logic [7:0] cmdByte;
		logic [7:0] respByte;
		int         count;
		layerPix_t  lp;
		logic [2:0] en;
		mixMode_e   md;
		RST_N = 1'b0;
		ce = 1'b1; // palette writes need ce on the cycle after the third byte
		host = '0;
		snd = '0;
		layers = '0;
		layerEn = 3'b000;
		p1 = 8'h00;
		p2 = 8'h00;
		p3 = 8'h00;
		sw1 = 8'h00;
		service = 1'(randBits(1));
		repeat (5) @(posedge CLK);
		#2;
		RST_N = 1'b1;

		beginTest();
		p1 = randBits(8);
		p2 = randBits(8);
		p3 = randBits(8);
		sw1 = randBits(8);
		hostRead(REG_STATUS, rdVal);
		checkByte("resetReads status", statusByte(1'b0, 1'b0), rdVal);
		checkByte("resetReads sndRstN", 8'h00, {7'b0000000, sndRstN});
		hostRead(REG_P1, rdVal);
		checkByte("resetReads P1", p1, rdVal);
		hostRead(REG_P2, rdVal);
		checkByte("resetReads P2", p2, rdVal);
		hostRead(REG_P3, rdVal);
		checkByte("resetReads P3", p3, rdVal);
		hostRead(REG_SW1, rdVal);
		checkByte("resetReads SW1", sw1, rdVal);
		hostRead(7'h7F, rdVal);
		checkByte("resetReads unmapped", 8'hFF, rdVal);
		endTest("resetReads");

		beginTest();
		start = randBits(8);
		count = 4 + int'(randBits(3));
		hostWrite(REG_PAL_ADDR, {8'h00, start});
		for (int i = 0; i < count; i++) begin
			idx = start + 8'(i); // wraps like the loader address
			cr = randBits(8);
			cg = randBits(8);
			cb = randBits(8);
			palModel[idx] = '{r: cr[5:0], g: cg[5:0], b: cb[5:0]};
			palTriple(cr, cg, cb);
		end
		hostWrite(REG_DISP_CTRL, {6'b000000, MIX_SPR_OVER, 8'h00});
		for (int i = 0; i < count; i++) begin
			idx = start + 8'(i);
			lp = '{bg0: idx, bg1: 8'h00, spr: 8'h00};
			pixStep("paletteLoad", lp, 3'b001, expand(palModel[idx]));
		end
		pixFlush("paletteLoad");
		endTest("paletteLoad");

		beginTest();
		hostWrite(REG_PAL_ADDR, 16'h0000);
		for (int i = 0; i < 256; i++) begin
			idx = 8'(i);
			palModel[idx] = '{r: idx[5:0], g: {4'b0000, idx[7:6]}, b: ~idx[5:0]};
			palTriple({2'b00, idx[5:0]}, {6'b000000, idx[7:6]}, {2'b00, ~idx[5:0]});
		end
		for (int m = 0; m < 4; m++) begin
			md = mixMode_e'(m[1:0]);
			hostWrite(REG_DISP_CTRL, {6'b000000, md, 8'h00});
			repeat (40) begin
				lp = '{bg0: randLayer(), bg1: randLayer(), spr: randLayer()};
				en = 3'(randBits(3));
				pixStep("mixPriority", lp, en, expand(palModel[mixRef(lp, en, md)]));
			end
			pixFlush("mixPriority");
		end
		endTest("mixPriority");

		beginTest();
		cmdByte = randBits(8);
		hostWrite(REG_SND_CMD, {8'h00, cmdByte});
		hostRead(REG_STATUS, rdVal);
		checkByte("sndCommand status set", statusByte(1'b1, 1'b0), rdVal);
		sndRead(SND_CMD_STAT, rdVal);
		checkByte("sndCommand stat pending", 8'h00, rdVal);
		sndRead(SND_DATA, rdVal);
		checkByte("sndCommand data", cmdByte, rdVal);
		hostRead(REG_STATUS, rdVal);
		checkByte("sndCommand status clear", statusByte(1'b0, 1'b0), rdVal);
		sndRead(SND_CMD_STAT, rdVal);
		checkByte("sndCommand stat idle", 8'h80, rdVal);
		endTest("sndCommand");

		beginTest();
		respByte = randBits(8);
		sndWrite(respByte);
		sndRead(SND_RESP_STAT, rdVal);
		checkByte("sndResponse stat pending", 8'h00, rdVal);
		hostRead(REG_STATUS, rdVal);
		checkByte("sndResponse status set", statusByte(1'b0, 1'b1), rdVal);
		hostRead(REG_SND_CMD, rdVal);
		checkByte("sndResponse data", respByte, rdVal);
		hostRead(REG_STATUS, rdVal);
		checkByte("sndResponse status clear", statusByte(1'b0, 1'b0), rdVal);
		sndRead(SND_RESP_STAT, rdVal);
		checkByte("sndResponse stat idle", 8'h80, rdVal);
		endTest("sndResponse");

		beginTest();
		checkByte("sndReset before", 8'h00, {7'b0000000, sndRstN});
		hostWrite(REG_MISC_CTRL, 16'h0008);
		checkByte("sndReset release", 8'h01, {7'b0000000, sndRstN});
		hostWrite(REG_MISC_CTRL, 16'hFFF7); // every bit but the release bit
		checkByte("sndReset hold", 8'h00, {7'b0000000, sndRstN});
		endTest("sndReset");

		$display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
